/* all.f */
+incdir+include
logic/soc_event_pkg.sv
logic/ref_clk_edge_detect.sv
logic/fc_event_map.sv
logic/event_queue.sv
logic/soc_event_unit.sv
test/tb_soc_event_unit.sv

/* Makefile */
# Verilator build and run of the event unit testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP      ?= tb_soc_event_unit
FILELIST ?= all.f
OBJ_DIR  ?= obj_dir

.PHONY: sim clean

# A $fatal in the testbench gives a non-zero exit status
sim:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* include/tb_event_table.svh */
//////////////////////////////////////////////////////////////////////
// Stimulus and expected-value rows for the event unit testbench.
// Included in the testbench module after the package import.
//////////////////////////////////////////////////////////////////////

`ifndef TB_EVENT_TABLE_SVH
`define TB_EVENT_TABLE_SVH

// Strobe vector: bit 0 dma_pe_evt, 1 dma_pe_irq, 2 pf_evt,
// 3..6 adv_timer, 7 gpio, 8..9 hwpe (bits 3..9 follow per_events_t)
// first is pulsed once with ready low, second follows reps times later
typedef struct packed {
    logic [9:0]      first;
    logic [9:0]      second;
    int              reps;
    int              stall;
    fc_events_t      fc;
    int              n_ids;
    logic [0:6][7:0] ids;
    int              n_err;
} row_t;

row_t  rows[$];
string names[$];

function automatic fc_events_t fc_bit(input int pos);
    return fc_events_t'(1) << pos;
endfunction

task automatic add_row(input string name, input logic [9:0] first,
                       input logic [9:0] second, input int reps, input int stall,
                       input fc_events_t fc, input int n_ids,
                       input logic [0:6][7:0] ids, input int n_err);
    row_t row;
    row.first  = first;
    row.second = second;
    row.reps   = reps;
    row.stall  = stall;
    row.fc     = fc;
    row.n_ids  = n_ids;
    row.ids    = ids;
    row.n_err  = n_err;
    rows.push_back(row);
    names.push_back(name);
endtask

task automatic fill_table();
    add_row("map_dma_evt", 10'h001, 10'h000, 0, 0, fc_bit(FC_BIT_DMA_PE_EVT), 0, 56'd0, 0);
    add_row("map_dma_irq", 10'h002, 10'h000, 0, 0, fc_bit(FC_BIT_DMA_PE_IRQ), 0, 56'd0, 0);
    add_row("map_pf_evt", 10'h004, 10'h000, 0, 0, fc_bit(FC_BIT_PF_EVT), 0, 56'd0, 0);
    add_row("id_adv0", 10'h008, 10'h000, 0, 0, fc_bit(FC_BIT_ADV_TIMER),
            1, {8'd135, 48'd0}, 0);
    add_row("id_adv1", 10'h010, 10'h000, 0, 0, fc_bit(FC_BIT_ADV_TIMER + 1),
            1, {8'd136, 48'd0}, 0);
    add_row("id_adv2", 10'h020, 10'h000, 0, 0, fc_bit(FC_BIT_ADV_TIMER + 2),
            1, {8'd137, 48'd0}, 0);
    add_row("id_adv3", 10'h040, 10'h000, 0, 0, fc_bit(FC_BIT_ADV_TIMER + 3),
            1, {8'd138, 48'd0}, 0);
    add_row("id_gpio", 10'h080, 10'h000, 0, 0, fc_bit(FC_BIT_GPIO), 1, {8'd139, 48'd0}, 0);
    add_row("id_hwpe0", 10'h100, 10'h000, 0, 0, 32'h0, 1, {8'd140, 48'd0}, 0);
    add_row("id_hwpe1", 10'h200, 10'h000, 0, 0, 32'h0, 1, {8'd141, 48'd0}, 0);
    // 138 sits in the output register before the rest arrive
    add_row("order_stall", 10'h040, 10'h1b0, 1, 6, fc_bit(FC_BIT_ADV_TIMER + 3),
            5, {8'd138, 8'd136, 8'd137, 8'd139, 8'd140, 16'd0}, 0);
    add_row("overflow_gpio", 10'h008, 10'h080, 2, 6, fc_bit(FC_BIT_ADV_TIMER),
            2, {8'd135, 8'd139, 40'd0}, 1);
    add_row("mixed_strobes", 10'h20d, 10'h000, 0, 3,
            fc_bit(FC_BIT_DMA_PE_EVT) | fc_bit(FC_BIT_PF_EVT) | fc_bit(FC_BIT_ADV_TIMER),
            2, {8'd135, 8'd141, 40'd0}, 0);
endtask

`endif

/* test/tb_soc_event_unit.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the SoC event unit. Applies the event table, checks
// the fabric-controller bit map, reference edges and the ID port.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_soc_event_unit;

    import soc_event_pkg::*;

    `include "tb_event_table.svh"

    localparam int DRAIN_TIMEOUT = 200;
    localparam int EDGE_TIMEOUT  = 20;

    // Bits that the map may ever drive
    localparam fc_events_t USED_BITS = (fc_events_t'(1) << FC_BIT_DMA_PE_EVT)
                                     | (fc_events_t'(1) << FC_BIT_DMA_PE_IRQ)
                                     | (fc_events_t'(1) << FC_BIT_PF_EVT)
                                     | (fc_events_t'(1) << FC_BIT_REF_EDGE)
                                     | (fc_events_t'(1) << FC_BIT_GPIO)
                                     | (fc_events_t'(4'hf) << FC_BIT_ADV_TIMER)
                                     | (fc_events_t'(1) << FC_BIT_ERR);

    logic       clk_i = 1'b0;
    logic       arst_n_i;
    logic       slow_clk_i;
    logic       dma_pe_evt_i;
    logic       dma_pe_irq_i;
    logic       pf_evt_i;
    logic [3:0] adv_timer_events_i;
    logic       gpio_event_i;
    logic [1:0] fc_hwpe_events_i;
    fc_events_t fc_events_o;
    logic       fc_event_valid_o;
    event_id_t  fc_event_data_o;
    logic       fc_event_ready_i;

    string           cur_name;
    logic [0:6][7:0] exp_ids;
    int              exp_n;
    int              got;
    int              err_seen;
    logic [31:0]     rng_state;

    soc_event_unit dut (
        .clk_i              ( clk_i              ),
        .arst_n_i           ( arst_n_i           ),
        .slow_clk_i         ( slow_clk_i         ),
        .dma_pe_evt_i       ( dma_pe_evt_i       ),
        .dma_pe_irq_i       ( dma_pe_irq_i       ),
        .pf_evt_i           ( pf_evt_i           ),
        .adv_timer_events_i ( adv_timer_events_i ),
        .gpio_event_i       ( gpio_event_i       ),
        .fc_hwpe_events_i   ( fc_hwpe_events_i   ),
        .fc_events_o        ( fc_events_o        ),
        .fc_event_valid_o   ( fc_event_valid_o   ),
        .fc_event_data_o    ( fc_event_data_o    ),
        .fc_event_ready_i   ( fc_event_ready_i   )
    );

    initial begin
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            stop_with_error("Mismatch between expected and actual value");
        end
    endtask

    task automatic set_strobes(input logic [9:0] s);
        dma_pe_evt_i       = s[0];
        dma_pe_irq_i       = s[1];
        pf_evt_i           = s[2];
        adv_timer_events_i = s[6:3];
        gpio_event_i       = s[7];
        fc_hwpe_events_i   = s[9:8];
    endtask

    //////////////////////////////////////////////////////////////////
    // One clock cycle, from falling edge to falling edge
    //////////////////////////////////////////////////////////////////
    task automatic advance_cycle();
        logic      was_valid;
        logic      was_ready;
        event_id_t was_data;
        was_valid = fc_event_valid_o;
        was_ready = fc_event_ready_i;
        was_data  = fc_event_data_o;
        @(negedge clk_i);
        check(cur_name, 32'h0, fc_events_o & ~USED_BITS);
        if (fc_events_o[FC_BIT_ERR] === 1'b1) begin
            err_seen++;
        end
        if (was_valid && was_ready) begin
            if (got >= exp_n) begin
                stop_with_error({"Unexpected extra ID transfer in test ", cur_name});
            end
            check(cur_name, 32'(exp_ids[got]), 32'(was_data));
            got++;
        end else if (was_valid) begin
            // Stalled offer must hold
            check(cur_name, 32'h1, 32'(fc_event_valid_o));
            check(cur_name, 32'(was_data), 32'(fc_event_data_o));
        end
    endtask

    task automatic check_ref_edges();
        int wait_cnt;
        cur_name = "ref_edges";
        for (int t = 0; t < 4; t++) begin
            slow_clk_i = ~slow_clk_i;
            wait_cnt   = 0;
            advance_cycle();
            while (fc_events_o[FC_BIT_REF_EDGE] !== 1'b1) begin
                if (wait_cnt == EDGE_TIMEOUT) begin
                    stop_with_error("Reference clock edge never reached fc_events_o bit 14");
                end
                advance_cycle();
                wait_cnt++;
            end
            // Exactly one pulse per toggle
            repeat (10) begin
                advance_cycle();
                check(cur_name, 32'h0, 32'(fc_events_o[FC_BIT_REF_EDGE]));
            end
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   wait_cnt;
        row      = rows[r];
        cur_name = names[r];
        exp_n    = row.n_ids;
        exp_ids  = row.ids;
        got      = 0;
        err_seen = 0;
        fc_event_ready_i = 1'b0;

        set_strobes(row.first);
        advance_cycle();
        check(cur_name, row.fc, fc_events_o);
        set_strobes(10'h000);
        // Mapped bits last a single cycle
        advance_cycle();
        check(cur_name, 32'h0, fc_events_o);
        repeat (3) advance_cycle();

        for (int k = 0; k < row.reps; k++) begin
            set_strobes(row.second);
            advance_cycle();
        end
        set_strobes(10'h000);
        repeat (row.stall) advance_cycle();

        // Drain with random ready stalls
        wait_cnt = 0;
        while (got < exp_n) begin
            if (wait_cnt == DRAIN_TIMEOUT) begin
                stop_with_error({"Expected event IDs never arrived in test ", cur_name});
            end
            rng_state        = xorshift32(rng_state);
            fc_event_ready_i = (rng_state[1:0] != 2'b00);
            advance_cycle();
            wait_cnt++;
        end
        fc_event_ready_i = 1'b1;
        repeat (8) advance_cycle();
        check(cur_name, row.n_err, err_seen);
        fc_event_ready_i = 1'b0;
    endtask

    initial begin
        arst_n_i         = 1'b0;
        slow_clk_i       = 1'b0;
        fc_event_ready_i = 1'b0;
        set_strobes(10'h000);
        rng_state = 32'h1d80de27;
        cur_name  = "reset";
        exp_ids   = '0;
        exp_n     = 0;
        got       = 0;
        err_seen  = 0;
        fill_table();

        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;
        advance_cycle();
        check(cur_name, 32'h0, fc_events_o);
        check(cur_name, 32'h0, 32'(fc_event_valid_o));

        check_ref_edges();
        for (int r = 0; r < rows.size(); r++) begin
            run_row(r);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* logic/soc_event_unit.sv */
//////////////////////////////////////////////////////////////////////
// Event routing top level. Chains the reference edge detector, the
// fabric-controller event map and the pending-event queue.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_event_unit (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      slow_clk_i,
    input  logic                      dma_pe_evt_i,
    input  logic                      dma_pe_irq_i,
    input  logic                      pf_evt_i,
    input  logic [3:0]                adv_timer_events_i,
    input  logic                      gpio_event_i,
    input  logic [1:0]                fc_hwpe_events_i,
    output soc_event_pkg::fc_events_t fc_events_o,
    output logic                      fc_event_valid_o,
    output soc_event_pkg::event_id_t  fc_event_data_o,
    input  logic                      fc_event_ready_i
);

    import soc_event_pkg::*;

    logic        ref_rise;
    logic        ref_fall;
    logic        err;
    per_events_t per_events_in;
    per_events_t per_events_map;

    // Peripheral strobes in ID order
    assign per_events_in.adv_timer = adv_timer_events_i;
    assign per_events_in.gpio      = gpio_event_i;
    assign per_events_in.hwpe      = fc_hwpe_events_i;

    ref_clk_edge_detect i_ref_edge (
        .clk_i      ( clk_i      ),
        .arst_n_i   ( arst_n_i   ),
        .slow_clk_i ( slow_clk_i ),
        .ref_rise_o ( ref_rise   ),
        .ref_fall_o ( ref_fall   )
    );

    fc_event_map i_fc_map (
        .clk_i        ( clk_i          ),
        .arst_n_i     ( arst_n_i       ),
        .ref_rise_i   ( ref_rise       ),
        .ref_fall_i   ( ref_fall       ),
        .dma_pe_evt_i ( dma_pe_evt_i   ),
        .dma_pe_irq_i ( dma_pe_irq_i   ),
        .pf_evt_i     ( pf_evt_i       ),
        .per_events_i ( per_events_in  ),
        .err_i        ( err            ),
        .fc_events_o  ( fc_events_o    ),
        .per_events_o ( per_events_map )
    );

    event_queue i_evt_queue (
        .clk_i         ( clk_i            ),
        .arst_n_i      ( arst_n_i         ),
        .per_events_i  ( per_events_map   ),
        .event_valid_o ( fc_event_valid_o ),
        .event_data_o  ( fc_event_data_o  ),
        .event_ready_i ( fc_event_ready_i ),
        .err_o         ( err              )
    );

endmodule

/* logic/event_queue.sv */
//////////////////////////////////////////////////////////////////////
// Pending-event queue. Keeps one flag per peripheral event, offers
// the lowest pending ID on a valid/ready port and strobes an error
// when an event arrives while still pending.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module event_queue (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  soc_event_pkg::per_events_t per_events_i,
    output logic                       event_valid_o,
    output soc_event_pkg::event_id_t   event_data_o,
    input  logic                       event_ready_i,
    output logic                       err_o
);

    import soc_event_pkg::*;

    logic [N_PER_EVENTS-1:0]         evt_in;
    logic [N_PER_EVENTS-1:0]         pending_q;
    logic [N_PER_EVENTS-1:0]         clear_mask;
    logic [$clog2(N_PER_EVENTS)-1:0] sel_idx;
    logic                            sel_found;
    logic                            out_free;
    logic                            load;
    logic                            valid_q;
    event_id_t                       data_q;
    logic                            err_q;

    // Struct bit i is peripheral event i
    assign evt_in = per_events_i;

    //////////////////////////////////////////////////////////////////
    // Lowest pending index
    //////////////////////////////////////////////////////////////////
    always_comb begin
        sel_idx = '0;
        for (int i = N_PER_EVENTS - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                sel_idx = i[$clog2(N_PER_EVENTS)-1:0];
            end
        end
    end

    assign sel_found = |pending_q;

    // Output register empty or handing its ID over this cycle
    assign out_free = ~valid_q | event_ready_i;
    assign load     = out_free & sel_found;

    always_comb begin
        clear_mask = '0;
        if (load) begin
            clear_mask[sel_idx] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Pending flags, output valid and overflow
    //////////////////////////////////////////////////////////////////

    // An arrival on a flag that is being loaded just re-arms it
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            valid_q   <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            pending_q <= (pending_q & ~clear_mask) | evt_in;
            err_q     <= |(evt_in & pending_q & ~clear_mask);
            if (load) begin
                valid_q <= 1'b1;
            end else if (event_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // ID payload, only meaningful while valid is high
    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= event_id_t'(PER_EVENT_BASE + int'(sel_idx));
        end
    end

    assign event_valid_o = valid_q;
    assign event_data_o  = data_q;
    assign err_o         = err_q;

endmodule

/* logic/fc_event_map.sv */
//////////////////////////////////////////////////////////////////////
// Places event strobes at their fixed fabric-controller bit positions
// and registers the vector together with the peripheral event struct.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fc_event_map (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       ref_rise_i,
    input  logic                       ref_fall_i,
    input  logic                       dma_pe_evt_i,
    input  logic                       dma_pe_irq_i,
    input  logic                       pf_evt_i,
    input  soc_event_pkg::per_events_t per_events_i,
    input  logic                       err_i,
    output soc_event_pkg::fc_events_t  fc_events_o,
    output soc_event_pkg::per_events_t per_events_o
);

    import soc_event_pkg::*;

    fc_events_t  fc_events_d;
    fc_events_t  fc_events_q;
    per_events_t per_events_q;

    //////////////////////////////////////////////////////////////////
    // Bit map
    //////////////////////////////////////////////////////////////////

    // Bits 0-7 stay free for software events
    // Timer unit bits 10/11 and high-priority bits 30/31 are unused here
    always_comb begin
        fc_events_d = '0;

        fc_events_d[FC_BIT_DMA_PE_EVT] = dma_pe_evt_i;
        fc_events_d[FC_BIT_DMA_PE_IRQ] = dma_pe_irq_i;
        fc_events_d[FC_BIT_PF_EVT]     = pf_evt_i;
        // Both reference edges share one bit
        fc_events_d[FC_BIT_REF_EDGE]   = ref_rise_i | ref_fall_i;
        fc_events_d[FC_BIT_GPIO]       = per_events_i.gpio;

        fc_events_d[FC_BIT_ADV_TIMER +: $bits(per_events_i.adv_timer)] =
            per_events_i.adv_timer;

        // Overflow from the event queue
        fc_events_d[FC_BIT_ERR]        = err_i;
    end

    //////////////////////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////////////////////

    // Same stage for both outputs, so the queue sees events in step
    // with fc_events_o
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fc_events_q  <= '0;
            per_events_q <= '0;
        end else begin
            fc_events_q  <= fc_events_d;
            per_events_q <= per_events_i;
        end
    end

    assign fc_events_o  = fc_events_q;
    assign per_events_o = per_events_q;

endmodule

/* logic/ref_clk_edge_detect.sv */
//////////////////////////////////////////////////////////////////////
// Brings the slow reference clock into the system clock domain and
// emits one-cycle strobes on its rising and falling edges.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ref_clk_edge_detect (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic slow_clk_i,
    output logic ref_rise_o,
    output logic ref_fall_o
);

    logic sync_q1;
    logic sync_q2;
    logic hist_q;
    logic rise_q;
    logic fall_q;

    // Two-flop synchronizer, then history for edge compare
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            hist_q  <= 1'b0;
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
        end else begin
            sync_q1 <= slow_clk_i;
            sync_q2 <= sync_q1;
            hist_q  <= sync_q2;
            rise_q  <= sync_q2 & ~hist_q;
            fall_q  <= ~sync_q2 & hist_q;
        end
    end

    assign ref_rise_o = rise_q;
    assign ref_fall_o = fall_q;

endmodule

/* logic/soc_event_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared widths, fabric-controller bit map and peripheral event
// struct for the SoC event routing pipeline. Imported by every stage
// and by the testbench.
//////////////////////////////////////////////////////////////////////

package soc_event_pkg;

    // Vector and ID widths
    localparam int FC_EVENT_W     = 32;
    localparam int EVNT_WIDTH     = 8;

    // Peripheral events served by the queue, IDs 135 to 141
    localparam int N_PER_EVENTS   = 7;
    localparam int PER_EVENT_BASE = 135;

    //////////////////////////////////////////////////////////////////
    // Fabric-controller event bit positions
    //////////////////////////////////////////////////////////////////
    localparam int FC_BIT_DMA_PE_EVT = 8;
    localparam int FC_BIT_DMA_PE_IRQ = 9;
    localparam int FC_BIT_PF_EVT     = 12;
    localparam int FC_BIT_REF_EDGE   = 14;
    localparam int FC_BIT_GPIO       = 15;
    // First of four advanced-timer bits
    localparam int FC_BIT_ADV_TIMER  = 17;
    localparam int FC_BIT_ERR        = 29;

    typedef logic [FC_EVENT_W-1:0] fc_events_t;
    typedef logic [EVNT_WIDTH-1:0] event_id_t;

    // Bit i of the struct is event ID PER_EVENT_BASE + i
    // First field sits at the MSB end
    typedef struct packed {
        // IDs 140 and 141
        logic [1:0] hwpe;
        // ID 139
        logic       gpio;
        // IDs 135 to 138
        logic [3:0] adv_timer;
    } per_events_t;

endpackage
